//--- logic/keccak_pkg.sv
`default_nettype none

package keccak_pkg;

    typedef logic [63:0] lane_t;

    // Element x of a row holds lane x of that row
    typedef lane_t [4:0] keccak_row_t;

    // Row a is y = 0 and row e is y = 4, so the flat lane index is x + 5 * y
    typedef struct packed {
        keccak_row_t rowa;
        keccak_row_t rowb;
        keccak_row_t rowc;
        keccak_row_t rowd;
        keccak_row_t rowe;
    } keccak_state_t;

    localparam int unsigned ROUNDS = 24;

    // Iota constants, one per round
    localparam lane_t ROUND_CONSTANTS [ROUNDS] = '{
        64'h0000_0000_0000_0001, 64'h0000_0000_0000_8082,
        64'h8000_0000_0000_808A, 64'h8000_0000_8000_8000,
        64'h0000_0000_0000_808B, 64'h0000_0000_8000_0001,
        64'h8000_0000_8000_8081, 64'h8000_0000_0000_8009,
        64'h0000_0000_0000_008A, 64'h0000_0000_0000_0088,
        64'h0000_0000_8000_8009, 64'h0000_0000_8000_000A,
        64'h0000_0000_8000_808B, 64'h8000_0000_0000_008B,
        64'h8000_0000_0000_8089, 64'h8000_0000_0000_8003,
        64'h8000_0000_0000_8002, 64'h8000_0000_0000_0080,
        64'h0000_0000_0000_800A, 64'h8000_0000_8000_000A,
        64'h8000_0000_8000_8081, 64'h8000_0000_0000_8080,
        64'h0000_0000_8000_0001, 64'h8000_0000_8000_8008
    };

    // Rho rotation amounts, indexed x + 5 * y like the lanes
    localparam int unsigned ROTATION_OFFSETS [25] = '{
         0,  1, 62, 28, 27,
        36, 44,  6, 55, 20,
         3, 10, 43, 25, 39,
        41, 45, 15, 21,  8,
        18,  2, 61, 56, 14
    };

    // Finalisation word placed above the nonce in row c, lane 2
    localparam logic [31:0] FINAL_WORD = 32'h0000_0006;

    // Closing pad bit, lives in row d, lane 1
    localparam lane_t PAD_LANE = 64'h8000_0000_0000_0000;

endpackage

`default_nettype wire

//--- logic/scan_pkg.sv
`default_nettype none

package scan_pkg;

    // Words of block template carried by one request
    localparam int unsigned TEMPLATE_WORDS = 24;

    // The start nonce is the upper half of row c, lane 0
    localparam int unsigned NONCE_WORD = 21;

    typedef logic [31:0] template_word_t;
    typedef template_word_t [TEMPLATE_WORDS-1:0] block_template_t;

    // Start is a single-cycle pulse, the rest must hold until the scanner is ready again
    typedef struct packed {
        logic            start;
        block_template_t block_template;
        logic [63:0]     threshold;
    } scan_request_t;

    // The offset counts from the start nonce, not from zero
    typedef struct packed {
        logic                      found;
        logic [31:0]               nonce_offset;
        keccak_pkg::keccak_state_t hash;
    } scan_result_t;

    typedef struct packed {
        logic ready;
        logic dispatching;
        logic evaluating;
    } scan_status_t;

endpackage

`default_nettype wire

//--- logic/keccak_round.sv
`default_nettype none

module keccak_round (
    input  keccak_pkg::keccak_state_t state_in,
    input  logic [4:0]                round_index,
    output keccak_pkg::keccak_state_t state_out
);
    import keccak_pkg::*;

    // All step arrays use the flat lane index x + 5 * y
    lane_t lanes     [25];
    lane_t theta_out [25];
    lane_t pi_out    [25];
    lane_t chi_out   [25];
    lane_t parity    [5];
    lane_t mix       [5];

    function automatic lane_t rotl(input lane_t value, input int unsigned amount);
        if (amount == 0) begin
            return value;
        end
        return (value << amount) | (value >> (64 - amount));
    endfunction

    always_comb begin
        for (int x = 0; x < 5; x++) begin
            lanes[x]      = state_in.rowa[x];
            lanes[x + 5]  = state_in.rowb[x];
            lanes[x + 10] = state_in.rowc[x];
            lanes[x + 15] = state_in.rowd[x];
            lanes[x + 20] = state_in.rowe[x];
        end
    end

    // Theta folds the parity of the two neighbouring columns into every lane
    always_comb begin
        for (int x = 0; x < 5; x++) begin
            parity[x] = lanes[x] ^ lanes[x + 5] ^ lanes[x + 10] ^ lanes[x + 15]
                ^ lanes[x + 20];
        end
        for (int x = 0; x < 5; x++) begin
            mix[x] = parity[(x + 4) % 5] ^ rotl(parity[(x + 1) % 5], 1);
        end
        for (int i = 0; i < 25; i++) begin
            theta_out[i] = lanes[i] ^ mix[i % 5];
        end
    end

    // Rho rotates each lane in place, pi then moves lane (x, y) to (y, 2x + 3y)
    always_comb begin
        for (int y = 0; y < 5; y++) begin
            for (int x = 0; x < 5; x++) begin
                pi_out[y + 5 * ((2 * x + 3 * y) % 5)] =
                    rotl(theta_out[x + 5 * y], ROTATION_OFFSETS[x + 5 * y]);
            end
        end
    end

    // Chi works along each row, iota only touches lane 0
    always_comb begin
        for (int y = 0; y < 5; y++) begin
            for (int x = 0; x < 5; x++) begin
                chi_out[x + 5 * y] = pi_out[x + 5 * y]
                    ^ (~pi_out[(x + 1) % 5 + 5 * y] & pi_out[(x + 2) % 5 + 5 * y]);
            end
        end
        chi_out[0] = chi_out[0] ^ ROUND_CONSTANTS[round_index];
    end

    always_comb begin
        for (int x = 0; x < 5; x++) begin
            state_out.rowa[x] = chi_out[x];
            state_out.rowb[x] = chi_out[x + 5];
            state_out.rowc[x] = chi_out[x + 10];
            state_out.rowd[x] = chi_out[x + 15];
            state_out.rowe[x] = chi_out[x + 20];
        end
    end

endmodule

`default_nettype wire

//--- logic/keccak_core.sv
`default_nettype none

module keccak_core (
    input  logic                      clk,
    input  logic                      rst_n,
    input  keccak_pkg::keccak_state_t in_state,
    input  logic                      in_sample,
    output logic                      ready,
    output keccak_pkg::keccak_state_t out_state,
    output logic                      out_sample
);
    import keccak_pkg::*;

    localparam logic [4:0] LAST_ROUND = 5'(ROUNDS - 1);

    keccak_state_t state_q;
    keccak_state_t round_in;
    keccak_state_t round_out;
    logic [4:0]    round_q;
    logic [4:0]    round_sel;
    logic          busy_q;
    logic          accept;

    assign ready  = ~busy_q;
    assign accept = in_sample & ~busy_q;

    // Round 0 runs on the accepting edge itself, so the final state is
    // registered 24 edges later and out_sample lines up with ready
    assign round_in  = busy_q ? state_q : in_state;
    assign round_sel = busy_q ? round_q : 5'd0;

    keccak_round i_keccak_round (
        .state_in    (round_in),
        .round_index (round_sel),
        .state_out   (round_out)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q     <= 1'b0;
            round_q    <= 5'd0;
            out_sample <= 1'b0;
        end else begin
            out_sample <= 1'b0;
            if (accept) begin
                busy_q  <= 1'b1;
                round_q <= 5'd1;
            end else if (busy_q) begin
                round_q <= round_q + 5'd1;
                if (round_q == LAST_ROUND) begin
                    busy_q     <= 1'b0;
                    out_sample <= 1'b1;
                end
            end
        end
    end

    // Holds the finished hash until the next accept
    always_ff @(posedge clk) begin
        if (accept || busy_q) begin
            state_q <= round_out;
        end
    end

    assign out_state = state_q;

endmodule

`default_nettype wire

//--- logic/scan_control.sv
`default_nettype none

module scan_control #(
    parameter logic [31:0] SCAN_LIMIT = 32'hFFFF_FFFF
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  scan_pkg::scan_request_t   request,
    output scan_pkg::scan_result_t    result,
    output scan_pkg::scan_status_t    status,
    input  logic                      core_ready,
    output keccak_pkg::keccak_state_t crunch_state,
    output logic                      crunch_sample,
    input  keccak_pkg::keccak_state_t hash_state,
    input  logic                      hash_sample
);
    import keccak_pkg::*;
    import scan_pkg::*;

    localparam int unsigned TEMPLATE_LANES = TEMPLATE_WORDS / 2;

    // A scan waits for a request, dispatches until a hit or the limit,
    // then lets the core drain before it accepts the next request
    typedef enum logic [2:0] {
        s_waiting     = 3'b001,
        s_dispatching = 3'b010,
        s_flushing    = 3'b100
    } scan_state_e;

    scan_state_e                  state_q;
    lane_t [TEMPLATE_LANES-1:0]   template_lanes;
    logic [31:0]                  nonce_q;
    logic [31:0]                  dispatch_count;
    logic [31:0]                  return_count;
    lane_t                        nonce_lane;
    lane_t                        hash_key;
    logic                         launch;
    logic                         exhausted;
    logic                         stop;
    logic                         accept;
    logic                         good_enough;
    scan_result_t                 result_q;

    assign launch    = (state_q == s_waiting) & request.start;
    assign exhausted = dispatch_count == SCAN_LIMIT;
    assign stop      = exhausted | result_q.found;

    // No new work once the scan is decided
    assign crunch_sample = (state_q == s_dispatching) & ~stop;
    assign accept        = crunch_sample & core_ready;

    assign status.ready       = state_q == s_waiting;
    assign status.dispatching = (state_q == s_dispatching) & core_ready;
    assign status.evaluating  = hash_sample;

    assign nonce_lane = {FINAL_WORD, nonce_q};

    // Template words pair up {odd, even} into lanes, filling rows a and b
    // and the first two lanes of row c
    assign crunch_state.rowa = template_lanes[4:0];
    assign crunch_state.rowb = template_lanes[9:5];
    assign crunch_state.rowc = {lane_t'(0), lane_t'(0), nonce_lane, template_lanes[11:10]};
    assign crunch_state.rowd = {lane_t'(0), lane_t'(0), lane_t'(0), PAD_LANE, lane_t'(0)};
    assign crunch_state.rowe = '0;

    always_ff @(posedge clk) begin
        if (launch) begin
            for (int i = 0; i < TEMPLATE_LANES; i++) begin
                template_lanes[i] <= {request.block_template[2 * i + 1],
                                      request.block_template[2 * i]};
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= s_waiting;
            nonce_q        <= '0;
            dispatch_count <= '0;
        end else begin
            case (state_q)
                s_waiting: begin
                    if (request.start) begin
                        nonce_q        <= request.block_template[NONCE_WORD];
                        dispatch_count <= '0;
                        state_q        <= s_dispatching;
                    end
                end
                s_dispatching: begin
                    if (stop) begin
                        state_q <= s_flushing;
                    end else if (accept) begin
                        // Nonce wraps modulo 2^32
                        nonce_q        <= nonce_q + 32'd1;
                        dispatch_count <= dispatch_count + 32'd1;
                    end
                end
                s_flushing: begin
                    // The core is idle only when it is ready and not handing out a hash
                    if (core_ready && !hash_sample) begin
                        state_q <= s_waiting;
                    end
                end
                default: begin
                    state_q <= s_waiting;
                end
            endcase
        end
    end

    // Lane 0 is compared as a big-endian number, hence the byte swap
    assign hash_key    = {<<8{hash_state.rowa[0]}};
    assign good_enough = hash_key < request.threshold;

    // Hashes come back in dispatch order, so the return index is the nonce offset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_q     <= '0;
            return_count <= '0;
        end else if (launch) begin
            result_q     <= '0;
            return_count <= '0;
        end else if (hash_sample) begin
            return_count <= return_count + 32'd1;
            if (!result_q.found && good_enough) begin
                result_q.found        <= 1'b1;
                result_q.nonce_offset <= return_count;
                result_q.hash         <= hash_state;
            end
        end
    end

    assign result = result_q;

endmodule

`default_nettype wire

//--- logic/sha3_scanner.sv
`default_nettype none

module sha3_scanner #(
    parameter logic [31:0] SCAN_LIMIT = 32'hFFFF_FFFF
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  scan_pkg::scan_request_t request,
    output scan_pkg::scan_result_t  result,
    output scan_pkg::scan_status_t  status
);
    import keccak_pkg::*;

    keccak_state_t crunch_state;
    keccak_state_t hash_state;
    logic          crunch_sample;
    logic          hash_sample;
    logic          core_ready;

    scan_control #(
        .SCAN_LIMIT (SCAN_LIMIT)
    ) i_scan_control (
        .clk           (clk),
        .rst_n         (rst_n),
        .request       (request),
        .result        (result),
        .status        (status),
        .core_ready    (core_ready),
        .crunch_state  (crunch_state),
        .crunch_sample (crunch_sample),
        .hash_state    (hash_state),
        .hash_sample   (hash_sample)
    );

    // One permutation in flight at a time
    keccak_core i_keccak_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_state   (crunch_state),
        .in_sample  (crunch_sample),
        .ready      (core_ready),
        .out_state  (hash_state),
        .out_sample (hash_sample)
    );

endmodule

`default_nettype wire

//--- tests/keccak_model.svh
`ifndef KECCAK_MODEL_SVH
`define KECCAK_MODEL_SVH

function automatic lane_t model_rotl(input lane_t value, input int amount);
    return (amount == 0) ? value : ((value << amount) | (value >> (64 - amount)));
endfunction

// Iota constant drawn seven bits per round from the bit generator x^8 + x^6 + x^5 + x^4 + 1
function automatic lane_t model_round_constant(input int round);
    logic [7:0] r;
    lane_t      rc;
    r  = 8'h01;
    rc = '0;
    for (int t = 0; t < 7 * round + 7; t++) begin
        if (t >= 7 * round && r[0]) begin
            rc[(1 << (t - 7 * round)) - 1] = 1'b1;
        end
        r = r[7] ? ({r[6:0], 1'b0} ^ 8'h71) : {r[6:0], 1'b0};
    end
    return rc;
endfunction

// Lanes are addressed as a[x][y], and row a of the state is y = 0
function automatic keccak_state_t model_permute(input keccak_state_t state);
    lane_t a   [5][5];
    lane_t b   [5][5];
    lane_t c   [5];
    lane_t d   [5];
    int    rot [5][5];
    int    x;
    int    y;
    int    tmp;
    // Rho offsets follow the triangular numbers along the (x, y) -> (y, 2x + 3y) walk
    rot[0][0] = 0;
    x = 1;
    y = 0;
    for (int t = 0; t < 24; t++) begin
        rot[x][y] = ((t + 1) * (t + 2) / 2) % 64;
        tmp = y;
        y = (2 * x + 3 * y) % 5;
        x = tmp;
    end
    for (int i = 0; i < 5; i++) begin
        a[i][0] = state.rowa[i];
        a[i][1] = state.rowb[i];
        a[i][2] = state.rowc[i];
        a[i][3] = state.rowd[i];
        a[i][4] = state.rowe[i];
    end
    for (int r = 0; r < 24; r++) begin
        for (int i = 0; i < 5; i++) begin
            c[i] = a[i][0] ^ a[i][1] ^ a[i][2] ^ a[i][3] ^ a[i][4];
        end
        for (int i = 0; i < 5; i++) begin
            d[i] = c[(i + 4) % 5] ^ model_rotl(c[(i + 1) % 5], 1);
        end
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                b[j][(2 * i + 3 * j) % 5] = model_rotl(a[i][j] ^ d[i], rot[i][j]);
            end
        end
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                a[i][j] = b[i][j] ^ (~b[(i + 1) % 5][j] & b[(i + 2) % 5][j]);
            end
        end
        a[0][0] ^= model_round_constant(r);
    end
    for (int i = 0; i < 5; i++) begin
        state.rowa[i] = a[i][0];
        state.rowb[i] = a[i][1];
        state.rowc[i] = a[i][2];
        state.rowd[i] = a[i][3];
        state.rowe[i] = a[i][4];
    end
    return state;
endfunction

// State handed to the core for one nonce
function automatic keccak_state_t model_block_state(input block_template_t tmpl,
                                                    input logic [31:0] nonce);
    keccak_state_t s;
    s = '0;
    for (int i = 0; i < 5; i++) begin
        s.rowa[i] = {tmpl[2 * i + 1], tmpl[2 * i]};
        s.rowb[i] = {tmpl[2 * i + 11], tmpl[2 * i + 10]};
    end
    s.rowc[0] = {tmpl[21], tmpl[20]};
    s.rowc[1] = {tmpl[23], tmpl[22]};
    s.rowc[2] = {32'h0000_0006, nonce};
    s.rowd[1] = 64'h8000_0000_0000_0000;
    return s;
endfunction

// Lane 0 read as a big-endian number
function automatic lane_t model_hash_key(input keccak_state_t hash);
    lane_t key;
    for (int i = 0; i < 8; i++) begin
        key[8 * i +: 8] = hash.rowa[0][56 - 8 * i +: 8];
    end
    return key;
endfunction

function automatic scan_result_t model_predict_scan(input block_template_t tmpl,
                                                    input logic [63:0] threshold,
                                                    input int unsigned limit);
    scan_result_t  r;
    keccak_state_t h;
    r = '0;
    for (int unsigned k = 0; k < limit; k++) begin
        h = model_permute(model_block_state(tmpl, 32'(tmpl[21] + k)));
        if (model_hash_key(h) < threshold) begin
            r.found        = 1'b1;
            r.nonce_offset = k;
            r.hash         = h;
            return r;
        end
    end
    return r;
endfunction

`endif

//--- tests/sha3_scanner_tb.sv
`default_nettype none

module sha3_scanner_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import keccak_pkg::*;
    import scan_pkg::*;

    localparam logic [31:0] SCAN_LIMIT      = 32'd40;
    localparam int          RANDOM_SCANS    = 6;
    localparam int          SCAN_COUNT      = RANDOM_SCANS + 4;
    localparam int          WATCHDOG_CYCLES = SCAN_COUNT * (int'(SCAN_LIMIT) + 2) * 26 + 200;
    localparam logic [63:0] HARD_THRESHOLD  = 64'h1000_0000_0000_0000;

    logic          clk;
    logic          rst_n;
    scan_request_t request;
    scan_result_t  result;
    scan_status_t  status;
    logic [31:0]   lfsr_state;
    scan_result_t  expected;
    logic          armed;
    logic          ready_prev    = 1'b1;
    int unsigned   returns       = 0;
    int unsigned   dispatches    = 0;
    int unsigned   scans_checked = 0;

    `include "keccak_model.svh"

    sha3_scanner #(
        .SCAN_LIMIT (SCAN_LIMIT)
    ) i_sha3_scanner (
        .clk     (clk),
        .rst_n   (rst_n),
        .request (request),
        .result  (result),
        .status  (status)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [1599:0] got,
                                   input logic [1599:0] exp);
        $display("FAIL %s got 0x%0h expected 0x%0h", name, got, exp);
        abort_run();
    endtask

    task automatic report_problem(input string what);
        $display("Error: %s", what);
        abort_run();
    endtask

    // Galois LFSR that is stepped once for every bit taken
    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    function automatic block_template_t random_template();
        block_template_t tmpl;
        for (int i = 0; i < TEMPLATE_WORDS; i++) begin
            tmpl[i] = random_bits(32);
        end
        return tmpl;
    endfunction

    // The start nonce is FFFFFFF0 and the threshold sits just above the best key
    // found, preferring a template whose best key lies past the wrap
    function automatic block_template_t wrapping_template(output logic [63:0] threshold);
        block_template_t tmpl;
        lane_t           key;
        lane_t           best_key;
        int              best_offset;
        for (int attempt = 0; attempt < 10; attempt++) begin
            tmpl = random_template();
            tmpl[21] = 32'hFFFF_FFF0;
            best_key = '1;
            best_offset = 0;
            for (int k = 0; k < int'(SCAN_LIMIT); k++) begin
                key = model_hash_key(model_permute(model_block_state(tmpl, 32'(tmpl[21] + k))));
                if (key < best_key) begin
                    best_key = key;
                    best_offset = k;
                end
            end
            if (best_offset >= 16) begin
                break;
            end
        end
        threshold = best_key + 64'd1;
        return tmpl;
    endfunction

    // A hit is evaluated the cycle after its hash returns, and the core takes the
    // next nonce in the return cycle, so one more dispatch follows a hit
    function automatic int unsigned expected_dispatches(input scan_result_t exp);
        if (!exp.found) begin
            return SCAN_LIMIT;
        end
        if (exp.nonce_offset + 2 > SCAN_LIMIT) begin
            return SCAN_LIMIT;
        end
        return exp.nonce_offset + 2;
    endfunction

    // Results are checked on the cycle where status.ready comes back after an accepted start
    always @(posedge clk) begin
        if (request.start && status.ready) begin
            returns    = 0;
            dispatches = 0;
        end else begin
            if (status.evaluating) begin
                returns = returns + 1;
            end
            if (status.dispatching) begin
                dispatches = dispatches + 1;
            end
        end
        if (armed && status.ready && !ready_prev) begin
            assert (result.found == expected.found)
                else report_mismatch("result.found", result.found, expected.found);
            if (expected.found) begin
                assert (result.nonce_offset == expected.nonce_offset)
                    else report_mismatch("result.nonce_offset", result.nonce_offset,
                                         expected.nonce_offset);
                assert (result.hash == expected.hash)
                    else report_mismatch("result.hash", result.hash, expected.hash);
                assert (returns >= expected.nonce_offset + 1
                        && returns <= expected.nonce_offset + 2)
                    else report_problem("the scanner kept dispatching after its hit");
            end else begin
                assert (returns == SCAN_LIMIT)
                    else report_mismatch("returned hash count", returns, SCAN_LIMIT);
            end
            assert (dispatches == expected_dispatches(expected))
                else report_mismatch("status.dispatching count", dispatches,
                                     expected_dispatches(expected));
            scans_checked = scans_checked + 1;
        end
        ready_prev = status.ready;
    end

    task automatic run_scan(input block_template_t tmpl, input logic [63:0] threshold,
                            input bit extra_start);
        int unsigned checked_before;
        checked_before = scans_checked;
        expected = model_predict_scan(tmpl, threshold, SCAN_LIMIT);
        @(negedge clk);
        request.block_template = tmpl;
        request.threshold = threshold;
        request.start = 1'b1;
        armed = 1'b1;
        @(negedge clk);
        request.start = 1'b0;
        if (extra_start) begin
            repeat (30) @(negedge clk);
            assert (!status.ready)
                else report_problem("scan ended before the second start pulse");
            request.start = 1'b1;
            @(negedge clk);
            request.start = 1'b0;
        end
        wait (scans_checked != checked_before);
        @(negedge clk);
        armed = 1'b0;
    endtask

    initial begin
        logic [63:0]     wrap_threshold;
        block_template_t wrap_tmpl;
        rst_n = 1'b0;
        request = '0;
        armed = 1'b0;
        expected = '0;
        lfsr_state = 32'd3;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (status.ready) else report_mismatch("status.ready", status.ready, 1'b1);
        assert (!result.found) else report_mismatch("result.found", result.found, 1'b0);

        run_scan(random_template(), '1, 1'b0);
        repeat (RANDOM_SCANS) begin
            run_scan(random_template(), HARD_THRESHOLD, 1'b0);
        end
        run_scan(random_template(), '0, 1'b0);
        wrap_tmpl = wrapping_template(wrap_threshold);
        run_scan(wrap_tmpl, wrap_threshold, 1'b0);
        run_scan(random_template(), HARD_THRESHOLD, 1'b1);

        if (scans_checked == SCAN_COUNT) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            report_problem("not every scan reached its result check");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_problem("watchdog expired before all scans finished");
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+tests
logic/keccak_pkg.sv
logic/scan_pkg.sv
logic/keccak_round.sv
logic/keccak_core.sv
logic/scan_control.sv
logic/sha3_scanner.sv
tests/sha3_scanner_tb.sv
